// ==== rv_core.f ====
rv_core_pkg.sv
rv_ctrl_if.sv
rv_control.sv
rv_pc_unit.sv
rv_reg_file.sv
rv_imm_gen.sv
rv_exec.sv
rv_lsu.sv
rv_core_top.sv
rv_clk_gen.sv
rv_core_assertions.sv
rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run rv_core_tb with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module rv_core_tb -f rv_core.f -o rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0

// ==== rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;

  localparam int rom_words = 64; // program slots, also sizes the watchdog
  localparam int mem_words = 64;

  logic        clk;
  logic        arst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        mem_read;
  logic        mem_write;
  logic [31:0] mem_rdata;
  logic        ebreak;

  logic [31:0] rom [rom_words];
  logic [31:0] mem [mem_words];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mem [mem_words];
  logic [31:0] ref_pc;
  // expectations per executed instruction
  logic [31:0] step_pc [$];
  logic [31:0] step_addr [$];
  logic [3:0]  step_mask [$];
  logic [31:0] step_data [$];
  int          seed = 13;

  rv_clk_gen i_rv_clk_gen (.clk(clk), .arst_n(arst_n));

  rv_core_top i_rv_core_top (.*);

  bind rv_core_top rv_core_assertions i_rv_core_assertions (
    .clk(clk), .arst_n(arst_n), .inst(inst), .pc(pc), .mem_wmask(mem_wmask),
    .mem_read(mem_read), .mem_write(mem_write), .ebreak(ebreak)
  );

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] lanes(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic report_failure(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // put one word at the model pc and record what it should do
  task automatic place(input logic [31:0] word, input logic [31:0] addr,
                       input logic [3:0] mask, input logic [31:0] data);
    logic [31:0] off;
    off = ref_pc - rv_core_pkg::reset_pc;
    rom[off[7:2]] = word;
    step_pc.push_back(ref_pc);
    step_addr.push_back(addr);
    step_mask.push_back(mask);
    step_data.push_back(data);
    ref_pc = ref_pc + 32'd4;
  endtask

  task automatic set_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) ref_regs[rd] = val;
  endtask

  task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
    place({imm, rd, rv_core_pkg::op_lui}, 32'h0, 4'b0000, 32'h0);
    set_reg(rd, {imm, 12'h000});
  endtask

  task automatic add_upper_pc(input logic [4:0] rd, input logic [19:0] imm);
    set_reg(rd, ref_pc + {imm, 12'h000});
    place({imm, rd, rv_core_pkg::op_auipc}, 32'h0, 4'b0000, 32'h0);
  endtask

  task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    place({imm, rs1, 3'b000, rd, rv_core_pkg::op_op_imm}, 32'h0, 4'b0000, 32'h0);
    set_reg(rd, ref_regs[rs1] + sext12(imm));
  endtask

  task automatic store_val(input logic [2:0] f3, input logic [4:0] rs2,
                           input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] word;
    logic [3:0]  mask;
    addr = ref_regs[rs1] + sext12(imm);
    case (f3)
      rv_core_pkg::f3_byte: begin
        mask = 4'b0001 << addr[1:0];
        word = {4{ref_regs[rs2][7:0]}}; // copy in every lane, mask picks one
      end
      rv_core_pkg::f3_half: begin
        mask = addr[1] ? 4'b1100 : 4'b0011;
        word = {2{ref_regs[rs2][15:0]}};
      end
      default: begin
        mask = 4'b1111;
        word = ref_regs[rs2];
      end
    endcase
    word = word & lanes(mask);
    ref_mem[addr[7:2]] = (ref_mem[addr[7:2]] & ~lanes(mask)) | word;
    place({imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::op_store}, addr, mask, word);
  endtask

  task automatic load_val(input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    addr = ref_regs[rs1] + sext12(imm);
    word = ref_mem[addr[7:2]];
    b    = word[{addr[1:0], 3'b000} +: 8];
    h    = addr[1] ? word[31:16] : word[15:0];
    case (f3)
      rv_core_pkg::f3_byte:   word = {{24{b[7]}}, b};
      rv_core_pkg::f3_byte_u: word = {24'h0, b};
      rv_core_pkg::f3_half:   word = {{16{h[15]}}, h};
      rv_core_pkg::f3_half_u: word = {16'h0, h};
      default: ;
    endcase
    place({imm, rs1, f3, rd, rv_core_pkg::op_load}, addr, 4'b0000, 32'h0);
    set_reg(rd, word);
  endtask

  task automatic jump_link(input logic [4:0] rd, input logic [20:0] off);
    logic [31:0] target;
    target = ref_pc + {{11{off[20]}}, off};
    set_reg(rd, ref_pc + 32'd4);
    place({off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::op_jal},
          32'h0, 4'b0000, 32'h0);
    ref_pc = target;
  endtask

  task automatic jump_reg(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] target;
    target = ref_regs[rs1] + sext12(imm);
    set_reg(rd, ref_pc + 32'd4);
    place({imm, rs1, 3'b000, rd, rv_core_pkg::op_jalr}, 32'h0, 4'b0000, 32'h0);
    ref_pc = target;
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = {12'(i), 5'd0, 3'b000, 5'd0, rv_core_pkg::op_op_imm}; // nop tagged by slot
      mem[i] = 32'h5a3c_9e17 ^ (32'(i) * 32'h0101_0101);
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;
    ref_pc = rv_core_pkg::reset_pc;
    add_imm(5'd1, 5'd0, 12'h040); // data base
    rnd = $random(seed);
    load_upper(5'd2, rnd[31:12]);
    store_val(rv_core_pkg::f3_word, 5'd2, 5'd1, 12'h000);
    rnd = $random(seed);
    add_upper_pc(5'd3, rnd[19:0]);
    store_val(rv_core_pkg::f3_word, 5'd3, 5'd1, 12'h004);
    rnd = $random(seed);
    add_imm(5'd4, 5'd2, rnd[11:0]);
    store_val(rv_core_pkg::f3_word, 5'd4, 5'd1, 12'h008);
    rnd = ($random(seed) | 32'h0000_8080) & 32'hffff_f7ff; // bits 15 and 7 set, imm positive
    load_upper(5'd5, rnd[31:12]);
    add_imm(5'd5, 5'd5, rnd[11:0]);
    for (int k = 0; k < 4; k++) store_val(rv_core_pkg::f3_byte, 5'd5, 5'd1, 12'(12 + k));
    store_val(rv_core_pkg::f3_half, 5'd5, 5'd1, 12'h010);
    store_val(rv_core_pkg::f3_half, 5'd5, 5'd1, 12'h012);
    store_val(rv_core_pkg::f3_word, 5'd5, 5'd1, 12'h014);
    load_val(rv_core_pkg::f3_byte, 5'd6, 5'd1, 12'h00e); // negative byte
    store_val(rv_core_pkg::f3_word, 5'd6, 5'd1, 12'h018);
    load_val(rv_core_pkg::f3_byte_u, 5'd7, 5'd1, 12'h00f);
    store_val(rv_core_pkg::f3_word, 5'd7, 5'd1, 12'h01c);
    load_val(rv_core_pkg::f3_half, 5'd8, 5'd1, 12'h012); // negative half
    store_val(rv_core_pkg::f3_word, 5'd8, 5'd1, 12'h020);
    load_val(rv_core_pkg::f3_half_u, 5'd9, 5'd1, 12'h010);
    store_val(rv_core_pkg::f3_word, 5'd9, 5'd1, 12'h024);
    load_val(rv_core_pkg::f3_word, 5'd10, 5'd1, 12'h014);
    store_val(rv_core_pkg::f3_word, 5'd10, 5'd1, 12'h028);
    jump_link(5'd11, 21'd8); // hops one slot
    store_val(rv_core_pkg::f3_word, 5'd11, 5'd1, 12'h02c);
    add_upper_pc(5'd12, 20'h0);
    jump_reg(5'd13, 5'd12, 12'h00c);
    store_val(rv_core_pkg::f3_word, 5'd13, 5'd1, 12'h030);
    place(32'h0010_0073, 32'h0, 4'b0000, 32'h0); // ebreak
  endtask

  initial begin
    int          step;
    logic [31:0] idx;
    logic [31:0] cur_addr;
    inst      = 32'h0000_0013;
    mem_rdata = 32'h0;
    step      = 0;
    build_program();
    wait (arst_n === 1'b1);
    forever begin
      assert (pc == step_pc[step])
        else report_failure($sformatf("pc %h, expected %h", pc, step_pc[step]));
      idx       = pc - rv_core_pkg::reset_pc;
      cur_addr  = step_addr[step];
      inst      = rom[idx[7:2]];
      mem_rdata = mem[cur_addr[7:2]];
      @(posedge clk);
      if (cur_addr != 32'h0) begin
        assert (mem_read && mem_addr == cur_addr)
          else report_failure($sformatf("mem_read %b mem_addr %h, expected a read at %h",
                                        mem_read, mem_addr, cur_addr));
      end else begin
        assert (!mem_read) else report_failure("memory read where none was expected");
      end
      if (step_mask[step] != 4'b0000) begin
        assert (mem_write && mem_wmask == step_mask[step])
          else report_failure($sformatf("wmask %b, expected %b", mem_wmask, step_mask[step]));
        assert ((mem_wdata & lanes(mem_wmask)) == step_data[step])
          else report_failure($sformatf("store data %h, expected %h",
                                        mem_wdata & lanes(mem_wmask), step_data[step]));
      end else begin
        assert (!mem_write) else report_failure("store where none was expected");
      end
      if (mem_write)
        mem[mem_addr[7:2]] = (mem[mem_addr[7:2]] & ~lanes(mem_wmask))
                             | (mem_wdata & lanes(mem_wmask));
      if (ebreak) break;
      step++;
      @(negedge clk);
    end
    if (step == step_pc.size() - 1) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure($sformatf("ebreak at step %0d, expected %0d", step, step_pc.size() - 1));
    end
  end

  // watchdog, four cycles per program slot
  initial begin
    wait (arst_n === 1'b1);
    repeat (rom_words * 4) @(posedge clk);
    $display("Timeout: the program did not reach ebreak within %0d cycles", rom_words * 4);
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

// ==== rv_core_assertions.sv ====
`timescale 1ns/10ps

module rv_core_assertions (
  input logic                         clk,
  input logic                         arst_n,
  input logic [rv_core_pkg::xlen-1:0] inst,
  input logic [rv_core_pkg::xlen-1:0] pc,
  input logic [3:0]                   mem_wmask,
  input logic                         mem_read,
  input logic                         mem_write,
  input logic                         ebreak
);

  logic [6:0] opcode;
  logic       is_jump;

  assign opcode  = inst[6:0];
  assign is_jump = (opcode == rv_core_pkg::op_jal) || (opcode == rv_core_pkg::op_jalr);

  // first edge out of reset still sees the reset vector
  reset_pc_a: assert property (@(posedge clk) $rose(arst_n) |-> pc == rv_core_pkg::reset_pc)
    else $error("pc is not the reset vector after reset");

  // straight-line flow
  seq_pc_a: assert property (@(posedge clk) disable iff (!arst_n)
    !is_jump |=> pc == $past(pc) + 32'd4)
    else $error("pc did not advance by 4 after a non-jump instruction");

  store_reads_a: assert property (@(posedge clk) disable iff (!arst_n)
    mem_write |-> mem_read)
    else $error("mem_write without mem_read");

  mask_needs_write_a: assert property (@(posedge clk) disable iff (!arst_n)
    mem_wmask != 4'b0000 |-> mem_write)
    else $error("byte mask set while no store is under way");

  ebreak_decode_a: assert property (@(posedge clk) disable iff (!arst_n)
    ebreak == (opcode == rv_core_pkg::op_system))
    else $error("ebreak does not follow the system opcode");

  // no memory traffic on the breakpoint
  ebreak_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
    ebreak |-> !mem_read && !mem_write && mem_wmask == 4'b0000)
    else $error("memory strobes active during ebreak");

endmodule

// ==== rv_clk_gen.sv ====
`timescale 1ns/10ps

module rv_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // released away from the rising edge
  end

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/10ps

module rv_core_top (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [rv_core_pkg::xlen-1:0] inst,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] mem_addr,
  output logic [rv_core_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]                   mem_wmask,
  output logic                         mem_read,
  output logic                         mem_write,
  input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
  output logic                         ebreak
);

  rv_core_pkg::inst_u           inst_view;
  logic [rv_core_pkg::xlen-1:0] pc_plus4;
  logic [rv_core_pkg::xlen-1:0] sum;
  logic [rv_core_pkg::xlen-1:0] rs1_data;
  logic [rv_core_pkg::xlen-1:0] rs2_data;
  logic [rv_core_pkg::xlen-1:0] wb_data;
  logic [rv_core_pkg::xlen-1:0] load_data;
  logic [rv_core_pkg::xlen-1:0] imm_i;
  logic [rv_core_pkg::xlen-1:0] imm_s;
  logic [rv_core_pkg::xlen-1:0] imm_u;
  logic [rv_core_pkg::xlen-1:0] imm_j;

  assign inst_view = rv_core_pkg::inst_u'(inst);

  rv_ctrl_if ctrl_bus ();

  rv_control i_rv_control (
    .inst   (inst_view),
    .ctrl   (ctrl_bus.ctrl),
    .ebreak (ebreak)
  );

  rv_pc_unit i_rv_pc_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl_bus.dp),
    .sum      (sum),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  rv_reg_file i_rv_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl_bus.dp),
    .rs1_addr (inst_view.i_fmt.rs1),
    .rs2_addr (inst_view.s_fmt.rs2),
    .rd_addr  (inst_view.i_fmt.rd),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_imm_gen i_rv_imm_gen (
    .inst  (inst_view),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_u (imm_u),
    .imm_j (imm_j)
  );

  rv_exec i_rv_exec (
    .ctrl      (ctrl_bus.dp),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .rs1_data  (rs1_data),
    .imm_i     (imm_i),
    .imm_s     (imm_s),
    .imm_u     (imm_u),
    .imm_j     (imm_j),
    .load_data (load_data),
    .sum       (sum),
    .wb_data   (wb_data)
  );

  rv_lsu i_rv_lsu (
    .ctrl      (ctrl_bus.dp),
    .inst      (inst_view),
    .addr      (sum),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .load_data (load_data)
  );

endmodule

// ==== rv_lsu.sv ====
`timescale 1ns/10ps

module rv_lsu (
  rv_ctrl_if.dp                        ctrl,
  input  rv_core_pkg::inst_u           inst,
  input  logic [rv_core_pkg::xlen-1:0] addr,
  input  logic [rv_core_pkg::xlen-1:0] rs2_data,
  input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
  output logic [rv_core_pkg::xlen-1:0] mem_addr,
  output logic [rv_core_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]                   mem_wmask,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic [rv_core_pkg::xlen-1:0] load_data
);

  logic [2:0]                   funct3;
  logic [1:0]                   offset;
  logic [4:0]                   lane_shift; // byte offset in bits
  logic [rv_core_pkg::xlen-1:0] rdata_shifted;
  logic [7:0]                   ld_byte;
  logic [15:0]                  ld_half;
  logic [3:0]                   st_mask;

  assign funct3     = inst.i_fmt.funct3;
  assign offset     = addr[1:0];
  assign lane_shift = {offset, 3'b000};

  always_comb begin
    st_mask   = 4'b0000;
    mem_wdata = '0;
    case (funct3)
      rv_core_pkg::f3_byte: begin
        st_mask   = 4'b0001 << offset;
        mem_wdata = {24'h0, rs2_data[7:0]} << lane_shift;
      end
      rv_core_pkg::f3_half: begin
        if (!offset[0]) begin // 0011 or 1100
          st_mask   = offset[1] ? 4'b1100 : 4'b0011;
          mem_wdata = {16'h0, rs2_data[15:0]} << lane_shift;
        end
      end
      rv_core_pkg::f3_word: begin
        if (offset == 2'b00) begin
          st_mask   = 4'b1111;
          mem_wdata = rs2_data;
        end
      end
      default: ;
    endcase
  end

  assign mem_wmask = ctrl.mem_write ? st_mask : 4'b0000;

  // addressed byte/half moved down to bit 0
  assign rdata_shifted = mem_rdata >> lane_shift;
  assign ld_byte       = rdata_shifted[7:0];
  assign ld_half       = rdata_shifted[15:0];

  always_comb begin
    load_data = '0; // misaligned half/word reads as zero
    case (funct3)
      rv_core_pkg::f3_byte:   load_data = {{24{ld_byte[7]}}, ld_byte};
      rv_core_pkg::f3_byte_u: load_data = {24'h0, ld_byte};
      rv_core_pkg::f3_half: begin
        if (!offset[0]) load_data = {{16{ld_half[15]}}, ld_half};
      end
      rv_core_pkg::f3_half_u: begin
        if (!offset[0]) load_data = {16'h0, ld_half};
      end
      rv_core_pkg::f3_word: begin
        if (offset == 2'b00) load_data = mem_rdata;
      end
      default: ;
    endcase
  end

  assign mem_addr  = addr; // full byte address
  assign mem_read  = ctrl.mem_read;
  assign mem_write = ctrl.mem_write;

endmodule

// ==== rv_exec.sv ====
`timescale 1ns/10ps

module rv_exec (
  rv_ctrl_if.dp                        ctrl,
  input  logic [rv_core_pkg::xlen-1:0] pc,
  input  logic [rv_core_pkg::xlen-1:0] pc_plus4,
  input  logic [rv_core_pkg::xlen-1:0] rs1_data,
  input  logic [rv_core_pkg::xlen-1:0] imm_i,
  input  logic [rv_core_pkg::xlen-1:0] imm_s,
  input  logic [rv_core_pkg::xlen-1:0] imm_u,
  input  logic [rv_core_pkg::xlen-1:0] imm_j,
  input  logic [rv_core_pkg::xlen-1:0] load_data,
  output logic [rv_core_pkg::xlen-1:0] sum,
  output logic [rv_core_pkg::xlen-1:0] wb_data
);

  logic [rv_core_pkg::xlen-1:0] op_a;
  logic [rv_core_pkg::xlen-1:0] op_b;

  always_comb begin
    case (ctrl.op_a_sel)
      rv_core_pkg::op_a_rs1: op_a = rs1_data;
      rv_core_pkg::op_a_pc:  op_a = pc;
      default:               op_a = '0; // lui
    endcase

    case (ctrl.op_b_sel)
      rv_core_pkg::op_b_imm_s: op_b = imm_s;
      rv_core_pkg::op_b_imm_u: op_b = imm_u;
      rv_core_pkg::op_b_imm_j: op_b = imm_j;
      default:                 op_b = imm_i;
    endcase
  end

  // single adder shared by alu result, address and jump target
  assign sum = op_a + op_b;

  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::wb_pc_plus4: wb_data = pc_plus4;
      rv_core_pkg::wb_load:     wb_data = load_data;
      default:                  wb_data = sum;
    endcase
  end

endmodule

// ==== rv_imm_gen.sv ====
`timescale 1ns/10ps

module rv_imm_gen (
  input  rv_core_pkg::inst_u           inst,
  output logic [rv_core_pkg::xlen-1:0] imm_i,
  output logic [rv_core_pkg::xlen-1:0] imm_s,
  output logic [rv_core_pkg::xlen-1:0] imm_u,
  output logic [rv_core_pkg::xlen-1:0] imm_j
);

  // addi, jalr, loads
  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};

  // stores, split field
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

  // upper 20 bits, low 12 zero
  assign imm_u = {inst.u_fmt.imm, 12'h000};

  // jal offset, bit 0 always zero
  assign imm_j = {
    {11{inst.j_fmt.imm_20}},
    inst.j_fmt.imm_20,
    inst.j_fmt.imm_19_12,
    inst.j_fmt.imm_11,
    inst.j_fmt.imm_10_1,
    1'b0
  };

endmodule

// ==== rv_reg_file.sv ====
`timescale 1ns/10ps

module rv_reg_file (
  input  logic                               clk,
  input  logic                               arst_n,
  rv_ctrl_if.dp                              ctrl,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_core_pkg::reg_addr_w-1:0] rd_addr,
  input  logic [rv_core_pkg::xlen-1:0]       wdata,
  output logic [rv_core_pkg::xlen-1:0]       rs1_data,
  output logic [rv_core_pkg::xlen-1:0]       rs2_data
);

  logic [rv_core_pkg::xlen-1:0] regs [2**rv_core_pkg::reg_addr_w];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**rv_core_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_we && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata; // x0 never written, so it reads zero
    end
  end

  // combinational reads, old value during the writing cycle
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

// ==== rv_pc_unit.sv ====
`timescale 1ns/10ps

module rv_pc_unit (
  input  logic                         clk,
  input  logic                         arst_n,
  rv_ctrl_if.dp                        ctrl,
  input  logic [rv_core_pkg::xlen-1:0] sum,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic [rv_core_pkg::xlen-1:0] pc_plus4
);

  logic [rv_core_pkg::xlen-1:0] next_pc;

  assign pc_plus4 = pc + 32'd4;

  // jalr target goes in without clearing bit 0
  assign next_pc = ctrl.pc_jump ? sum : pc_plus4;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_core_pkg::reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== rv_control.sv ====
`timescale 1ns/10ps

module rv_control (
  input  rv_core_pkg::inst_u inst,
  rv_ctrl_if.ctrl            ctrl,
  output logic               ebreak
);

  logic [6:0] opcode;

  assign opcode = inst.i_fmt.opcode;

  always_comb begin
    // unknown opcodes add zero to imm_i and fall through to pc+4
    ctrl.reg_we    = 1'b1;
    ctrl.op_a_sel  = rv_core_pkg::op_a_zero;
    ctrl.op_b_sel  = rv_core_pkg::op_b_imm_i;
    ctrl.wb_sel    = rv_core_pkg::wb_sum;
    ctrl.pc_jump   = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;

    case (opcode)
      rv_core_pkg::op_op_imm: begin
        ctrl.op_a_sel = rv_core_pkg::op_a_rs1; // every funct3 runs as addi
      end
      rv_core_pkg::op_lui: begin
        ctrl.op_b_sel = rv_core_pkg::op_b_imm_u;
      end
      rv_core_pkg::op_auipc: begin
        ctrl.op_a_sel = rv_core_pkg::op_a_pc;
        ctrl.op_b_sel = rv_core_pkg::op_b_imm_u;
      end
      rv_core_pkg::op_jal: begin
        ctrl.op_a_sel = rv_core_pkg::op_a_pc;
        ctrl.op_b_sel = rv_core_pkg::op_b_imm_j;
        ctrl.wb_sel   = rv_core_pkg::wb_pc_plus4; // link
        ctrl.pc_jump  = 1'b1;
      end
      rv_core_pkg::op_jalr: begin
        ctrl.op_a_sel = rv_core_pkg::op_a_rs1;
        ctrl.wb_sel   = rv_core_pkg::wb_pc_plus4;
        ctrl.pc_jump  = 1'b1;
      end
      rv_core_pkg::op_load: begin
        ctrl.op_a_sel = rv_core_pkg::op_a_rs1;
        ctrl.wb_sel   = rv_core_pkg::wb_load;
        ctrl.mem_read = 1'b1;
      end
      rv_core_pkg::op_store: begin
        ctrl.reg_we    = 1'b0;
        ctrl.op_a_sel  = rv_core_pkg::op_a_rs1;
        ctrl.op_b_sel  = rv_core_pkg::op_b_imm_s;
        ctrl.mem_read  = 1'b1; // read strobe stays up on stores too
        ctrl.mem_write = 1'b1;
      end
      rv_core_pkg::op_branch: ctrl.reg_we = 1'b0;
      rv_core_pkg::op_system: ctrl.reg_we = 1'b0;
      default: ;
    endcase
  end

  assign ebreak = (opcode == rv_core_pkg::op_system);

endmodule

// ==== rv_ctrl_if.sv ====
`timescale 1ns/10ps

interface rv_ctrl_if;

  logic                   reg_we;
  rv_core_pkg::op_a_sel_e op_a_sel;
  rv_core_pkg::op_b_sel_e op_b_sel;
  rv_core_pkg::wb_sel_e   wb_sel;
  logic                   pc_jump;   // next pc from the adder
  logic                   mem_read;
  logic                   mem_write;

  modport ctrl (
    output reg_we, op_a_sel, op_b_sel, wb_sel, pc_jump, mem_read, mem_write
  );

  modport dp (
    input reg_we, op_a_sel, op_b_sel, wb_sel, pc_jump, mem_read, mem_write
  );

endinterface

// ==== rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] op_op_imm = 7'b001_0011;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_branch = 7'b110_0011; // decoded only to block the reg write
  localparam logic [6:0] op_system = 7'b111_0011;

  // load/store width codes
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo; // sits where rd would be
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // one instruction word, four field layouts
  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef enum logic [1:0] {op_a_zero, op_a_rs1, op_a_pc} op_a_sel_e;
  typedef enum logic [1:0] {op_b_imm_i, op_b_imm_s, op_b_imm_u, op_b_imm_j} op_b_sel_e;
  typedef enum logic [1:0] {wb_sum, wb_pc_plus4, wb_load} wb_sel_e;

endpackage
